//--- logic/rob_pkg.sv
package rob_pkg;

    // buffer and register file sizes.
    localparam int ROB_DEPTH = 16;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);
    localparam int ARCH_REG_W = $clog2(ARCH_REGS);
    localparam int PHYS_REG_W = $clog2(PHYS_REGS);

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // one extra bit so a full buffer is distinct from an empty one.
    typedef logic [ROB_IDX_W:0] rob_cnt_t;

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

    // one renamed destination.
    typedef struct packed {
        arch_reg_t arch;
        phys_reg_t phys;
        phys_reg_t old_phys;
    } rob_entry_t;

    // allocation request from the mapper.
    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } rob_alloc_t;

    // completion notice, by buffer index.
    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } rob_finish_t;

    // entry handed back to the mapper on commit or rollback.
    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } rob_release_t;

    typedef enum logic {
        ROB_RUN   = 1'b0,
        ROB_FLUSH = 1'b1
    } rob_state_t;

endpackage

//--- logic/rob_ptr_counter.sv
`timescale 1ns/1ns

module rob_ptr_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_en,
    input  logic              retire_en,
    input  logic              rollback_en,
    output rob_pkg::rob_idx_t rd_ptr,
    output rob_pkg::rob_idx_t wr_ptr,
    output rob_pkg::rob_idx_t last_ptr,
    output logic              empty
);

    import rob_pkg::*;

    rob_idx_t rd_ptr_q;
    rob_idx_t wr_ptr_q;
    rob_idx_t rd_ptr_next;
    rob_idx_t wr_ptr_next;
    rob_cnt_t count;
    rob_cnt_t count_next;
    logic     release_en;

    // retire and rollback never happen in the same cycle.
    assign release_en = retire_en || rollback_en;

    // depth is a power of two, so index arithmetic wraps by itself.
    always_comb begin
        rd_ptr_next = rd_ptr_q;
        wr_ptr_next = wr_ptr_q;

        if (retire_en) begin
            rd_ptr_next = rd_ptr_q + 1'b1;
        end

        if (rollback_en) begin
            wr_ptr_next = wr_ptr_q - 1'b1;
        end else if (alloc_en) begin
            wr_ptr_next = wr_ptr_q + 1'b1;
        end
    end

    always_comb begin
        count_next = count;
        if (alloc_en && !release_en) begin
            count_next = count + 1'b1;
        end else if (!alloc_en && release_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_next;
            wr_ptr_q <= wr_ptr_next;
            count    <= count_next;
        end
    end

    assign rd_ptr = rd_ptr_q;
    assign wr_ptr = wr_ptr_q;

    // youngest live entry sits just behind the tail.
    assign last_ptr = wr_ptr_q - 1'b1;

    assign empty = (count == '0);

endmodule

//--- logic/rob_entry_store.sv
`timescale 1ns/1ns

module rob_entry_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rob_pkg::rob_alloc_t  alloc,
    input  rob_pkg::rob_idx_t    wr_ptr,
    input  rob_pkg::rob_idx_t    rd_ptr,
    input  rob_pkg::rob_idx_t    last_ptr,
    input  rob_pkg::rob_finish_t finish,
    input  logic                 flushing,
    output rob_pkg::rob_entry_t  head_entry,
    output rob_pkg::rob_entry_t  tail_entry,
    output logic                 head_done
);

    import rob_pkg::*;

    rob_entry_t             entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]   done;
    logic                   finish_ok;

    // completions that land during a flush belong to squashed work.
    assign finish_ok = finish.valid && !flushing;

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            entries[wr_ptr] <= alloc.entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= '0;
        end else begin
            if (finish_ok) begin
                done[finish.idx] <= 1'b1;
            end
            // a fresh entry always starts unfinished.
            if (alloc.valid) begin
                done[wr_ptr] <= 1'b0;
            end
        end
    end

    // oldest entry for retirement.
    assign head_entry = entries[rd_ptr];
    assign head_done  = done[rd_ptr];

    // youngest entry for rollback.
    assign tail_entry = entries[last_ptr];

endmodule

//--- logic/rob_ctrl.sv
`timescale 1ns/1ns

module rob_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  except,
    input  logic                  empty,
    input  logic                  head_done,
    input  rob_pkg::rob_entry_t   head_entry,
    input  rob_pkg::rob_entry_t   tail_entry,
    output logic                  retire_en,
    output logic                  rollback_en,
    output logic                  credit_return,
    output logic                  flushing,
    output rob_pkg::rob_release_t commit,
    output rob_pkg::rob_release_t rollback
);

    import rob_pkg::*;

    rob_state_t state;
    rob_state_t state_next;
    logic       in_run;
    logic       in_flush;

    assign in_run   = (state == ROB_RUN);
    assign in_flush = (state == ROB_FLUSH);

    always_comb begin
        state_next = state;
        case (state)
            ROB_RUN: begin
                if (except) begin
                    state_next = ROB_FLUSH;
                end
            end
            ROB_FLUSH: begin
                // leave once the last rollback has drained the buffer.
                if (empty) begin
                    state_next = ROB_RUN;
                end
            end
            default: state_next = ROB_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ROB_RUN;
        end else begin
            state <= state_next;
        end
    end

    // oldest entry leaves only once finished, never in the except cycle.
    assign retire_en = in_run && !empty && head_done && !except;

    // walk back from the youngest entry, one per cycle.
    assign rollback_en = in_flush && !empty;

    assign flushing      = rollback_en;
    assign credit_return = retire_en || rollback_en;

    always_comb begin
        commit.valid   = retire_en;
        commit.entry   = head_entry;
        rollback.valid = rollback_en;
        rollback.entry = tail_entry;
    end

endmodule

//--- logic/rob_top.sv
`timescale 1ns/1ns

module rob_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rob_pkg::rob_alloc_t   alloc,
    output rob_pkg::rob_idx_t     alloc_idx,
    input  rob_pkg::rob_finish_t  finish,
    input  logic                  except,
    output rob_pkg::rob_release_t commit,
    output rob_pkg::rob_release_t rollback,
    output logic                  credit_return,
    output logic                  flushing
);

    import rob_pkg::*;

    rob_idx_t   rd_ptr;
    rob_idx_t   wr_ptr;
    rob_idx_t   last_ptr;
    logic       empty;
    logic       retire_en;
    logic       rollback_en;
    logic       head_done;
    rob_entry_t head_entry;
    rob_entry_t tail_entry;

    // next allocation lands at the tail.
    assign alloc_idx = wr_ptr;

    rob_ptr_counter ptr_counter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_en    (alloc.valid),
        .retire_en   (retire_en),
        .rollback_en (rollback_en),
        .rd_ptr      (rd_ptr),
        .wr_ptr      (wr_ptr),
        .last_ptr    (last_ptr),
        .empty       (empty)
    );

    rob_entry_store entry_store_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .last_ptr   (last_ptr),
        .finish     (finish),
        .flushing   (flushing),
        .head_entry (head_entry),
        .tail_entry (tail_entry),
        .head_done  (head_done)
    );

    rob_ctrl ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .except        (except),
        .empty         (empty),
        .head_done     (head_done),
        .head_entry    (head_entry),
        .tail_entry    (tail_entry),
        .retire_en     (retire_en),
        .rollback_en   (rollback_en),
        .credit_return (credit_return),
        .flushing      (flushing),
        .commit        (commit),
        .rollback      (rollback)
    );

endmodule

//--- bench/rob_checks.svh
`ifndef ROB_CHECKS_SVH
`define ROB_CHECKS_SVH

// entry carried by commit or rollback.
task automatic check_release(
    input string      name,
    input rob_entry_t exp,
    input rob_entry_t act
);
    if (act !== exp) begin
        $display("Mismatch in %s: expected %0d/%0d/%0d, actual %0d/%0d/%0d (arch/phys/old_phys)",
            name, exp.arch, exp.phys, exp.old_phys, act.arch, act.phys, act.old_phys);
        stop_on_failure();
    end
endtask

task automatic check_idx(
    input string    name,
    input rob_idx_t exp,
    input rob_idx_t act
);
    if (act !== exp) begin
        $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        stop_on_failure();
    end
endtask

// single control outputs.
task automatic check_bit(
    input string name,
    input logic  exp,
    input logic  act
);
    if (act !== exp) begin
        $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
        stop_on_failure();
    end
endtask

// credits held on the mapper side.
task automatic check_count(
    input string    name,
    input rob_cnt_t exp,
    input rob_cnt_t act
);
    if (act !== exp) begin
        $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        stop_on_failure();
    end
endtask

`endif

//--- bench/rob_tb.sv
`timescale 1ns/1ns

module rob_tb;

    import rob_pkg::*;

    localparam int N_OPS       = 2000;
    localparam int WATCHDOG_NS = (N_OPS + 4 * ROB_DEPTH + 20) * 100;

    // one expected buffer entry.
    typedef struct packed {
        rob_idx_t   idx;
        rob_entry_t entry;
        logic       fin;
    } model_entry_t;

    logic         clk;
    logic         rst_n;
    rob_alloc_t   alloc;
    rob_idx_t     alloc_idx;
    rob_finish_t  finish;
    logic         except;
    rob_release_t commit;
    rob_release_t rollback;
    logic         credit_return;
    logic         flushing;

    integer         seed;
    int             cycle;
    int             oldest;
    int             credits;
    rob_state_t     m_state;
    model_entry_t   q[$];

    rob_top rob_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (alloc),
        .alloc_idx     (alloc_idx),
        .finish        (finish),
        .except        (except),
        .commit        (commit),
        .rollback      (rollback),
        .credit_return (credit_return),
        .flushing      (flushing)
    );

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "rob_checks.svh"

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $unsigned($random(seed));
        return int'(r % n);
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the run completed");
        stop_on_failure();
    end

    // one clock of stimulus, output checks and model update.
    task automatic run_cycle(input logic allow_new);
        logic         do_except;
        logic         do_alloc;
        logic         do_finish;
        logic         exp_commit;
        logic         exp_rollback;
        logic         exp_flushing;
        int           pick;
        int           open_slots[$];
        rob_idx_t     next_idx;
        rob_entry_t   new_entry;
        rob_alloc_t   alloc_req;
        rob_finish_t  fin_req;
        model_entry_t slot;
        string        tag;

        @(negedge clk);
        cycle = cycle + 1;
        tag = $sformatf("cycle %0d", cycle);
        exp_flushing = (m_state == ROB_FLUSH) && (q.size() != 0);
        next_idx = rob_idx_t'((oldest + q.size()) % ROB_DEPTH);

        do_except = allow_new && (m_state == ROB_RUN) && (rand_below(64) == 0);
        do_alloc = allow_new && !do_except && !exp_flushing && (credits > 0)
            && (rand_below(10) < 7);

        foreach (q[i]) begin
            if (!q[i].fin) begin
                open_slots.push_back(i);
            end
        end
        do_finish = (open_slots.size() != 0) && (!allow_new || rand_below(2) == 0);

        alloc_req = '0;
        if (do_alloc) begin
            new_entry.arch     = arch_reg_t'(rand_below(ARCH_REGS));
            new_entry.phys     = phys_reg_t'(rand_below(PHYS_REGS));
            new_entry.old_phys = phys_reg_t'(rand_below(PHYS_REGS));
            alloc_req.valid    = 1'b1;
            alloc_req.entry    = new_entry;
        end

        fin_req = '0;
        pick = 0;
        if (do_finish) begin
            pick = open_slots[rand_below(open_slots.size())];
            fin_req.valid = 1'b1;
            fin_req.idx   = q[pick].idx;
        end

        alloc  = alloc_req;
        finish = fin_req;
        except = do_except;
        #1;

        // oldest leaves only when finished in an earlier cycle.
        exp_commit = (m_state == ROB_RUN) && (q.size() != 0) && q[0].fin && !do_except;
        exp_rollback = exp_flushing;

        check_idx({tag, " alloc_idx"}, next_idx, alloc_idx);
        check_bit({tag, " commit valid"}, exp_commit, commit.valid);
        check_bit({tag, " rollback valid"}, exp_rollback, rollback.valid);
        check_bit({tag, " flushing"}, exp_flushing, flushing);
        check_bit({tag, " credit_return"}, exp_commit || exp_rollback, credit_return);
        if (exp_commit) begin
            check_release({tag, " commit entry"}, q[0].entry, commit.entry);
        end
        if (exp_rollback) begin
            check_release({tag, " rollback entry"}, q[q.size() - 1].entry, rollback.entry);
        end

        // state after the coming rising edge.
        if (do_finish && !exp_flushing) begin
            q[pick].fin = 1'b1;
        end
        if (exp_commit) begin
            void'(q.pop_front());
            oldest = (oldest + 1) % ROB_DEPTH;
        end
        if (exp_rollback) begin
            void'(q.pop_back());
        end
        if (do_alloc) begin
            slot.idx   = next_idx;
            slot.entry = alloc_req.entry;
            slot.fin   = 1'b0;
            q.push_back(slot);
        end

        if (credit_return) begin
            credits = credits + 1;
        end
        if (do_alloc) begin
            credits = credits - 1;
        end
        if (credits < 0 || credits > ROB_DEPTH) begin
            $display("credit count left its range at %s: %0d", tag, credits);
            stop_on_failure();
        end
        check_count({tag, " credits"}, rob_cnt_t'(ROB_DEPTH - q.size()), rob_cnt_t'(credits));

        if (m_state == ROB_RUN) begin
            if (do_except) begin
                m_state = ROB_FLUSH;
            end
        end else if (!exp_flushing) begin
            m_state = ROB_RUN;
        end
    endtask

    initial begin
        seed    = 32'h8b70_5ca5;
        rst_n   = 1'b0;
        alloc   = '0;
        finish  = '0;
        except  = 1'b0;
        cycle   = 0;
        oldest  = 0;
        credits = ROB_DEPTH;
        m_state = ROB_RUN;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("reset commit valid", 1'b0, commit.valid);
        check_bit("reset rollback valid", 1'b0, rollback.valid);
        check_bit("reset credit_return", 1'b0, credit_return);
        check_bit("reset flushing", 1'b0, flushing);
        check_idx("reset alloc_idx", '0, alloc_idx);

        repeat (N_OPS) run_cycle(1'b1);

        // drain by finishing everything left and letting any flush end.
        while (q.size() != 0 || m_state == ROB_FLUSH) begin
            run_cycle(1'b0);
        end

        @(negedge clk);
        alloc  = '0;
        finish = '0;
        except = 1'b0;
        #1;
        check_bit("drained commit valid", 1'b0, commit.valid);
        check_bit("drained rollback valid", 1'b0, rollback.valid);
        check_bit("drained flushing", 1'b0, flushing);
        check_bit("drained credit_return", 1'b0, credit_return);
        check_idx("drained alloc_idx", rob_idx_t'(oldest), alloc_idx);
        check_count("drained credits", rob_cnt_t'(ROB_DEPTH), rob_cnt_t'(credits));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- sim.f
+incdir+bench
logic/rob_pkg.sv
logic/rob_ptr_counter.sv
logic/rob_entry_store.sv
logic/rob_ctrl.sv
logic/rob_top.sv
bench/rob_tb.sv

//--- run.sh
#!/bin/sh
# Build the reorder buffer testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the run hits $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rob_tb -f sim.f -o rob_sim \
    && ./obj_dir/rob_sim \
    || { echo "simulation failed"; exit 1; }
